// ==== rtl/change_fifo.sv ====
module change_fifo
        import vend_pkg::*;
(
        input  logic  clk,
        input  logic  rst,
        input  logic  push,                             // never while full
        input  coin_t push_coin,
        input  logic  pop,                              // never while empty
        output coin_t head_coin,                        // oldest queued coin
        output logic  full,
        output logic  empty
);

        coin_t              mem [FIFO_DEPTH];           // coin storage
        logic [FIFO_AW-1:0] wr_ptr;
        logic [FIFO_AW-1:0] rd_ptr;
        logic [FIFO_AW:0]   count;                      // occupancy 0..FIFO_DEPTH

        assign head_coin = mem[rd_ptr];
        assign full      = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
        assign empty     = (count == '0);

        always_ff @(posedge clk) begin
                if (push) begin
                        mem[wr_ptr] <= push_coin;
                end
        end

        // pointers wrap at the power of two depth
        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (pop) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        case ({push, pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;        // both or neither
                        endcase
                end
        end

endmodule

// ==== rtl/coin_hopper.sv ====
module coin_hopper
        import vend_pkg::*;
(
        input  logic  clk,
        input  logic  rst,
        input  coin_t head_coin,                        // coin at the queue head
        input  logic  empty,
        output logic  pop,                              // take head coin this cycle
        output logic  ret1,                             // payout pulses, one hot
        output logic  ret2,
        output logic  ret5
);

        logic [$clog2(HOPPER_GAP + 1)-1:0] gap_q;      // recovery countdown

        // only pop when recovered and a coin waits
        assign pop = (gap_q == '0) && !empty;

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        gap_q <= '0;
                        ret1  <= 1'b0;
                        ret2  <= 1'b0;
                        ret5  <= 1'b0;
                end else begin
                        ret1 <= pop && (head_coin == COIN_1);   // pulse a cycle after pop
                        ret2 <= pop && (head_coin == COIN_2);
                        ret5 <= pop && (head_coin == COIN_5);
                        if (pop) begin
                                gap_q <= $bits(gap_q)'(HOPPER_GAP); // next pop 4 cycles on
                        end else if (gap_q != '0) begin
                                gap_q <= gap_q - 1'b1;
                        end
                end
        end

endmodule

// ==== rtl/vend_credit.sv ====
module vend_credit
        import vend_pkg::*;
(
        input  logic    clk,
        input  logic    rst,
        input  logic    coin1_n,                        // active low coin strobes
        input  logic    coin2_n,
        input  logic    coin5_n,
        input  logic    water_n,                        // buy water
        input  logic    refund_n,                       // give all credit back
        input  logic    full,                           // change queue full
        output credit_t credit,
        output logic    vend_water,                     // one cycle pulse per sale
        output logic    busy,                           // change still being queued
        output logic    push,                           // write into change queue
        output coin_t   push_coin
);

        credit_t change_q;                              // change left to hand out
        logic    coin_in;                               // some coin strobe low
        coin_t   in_coin;                               // highest priority coin strobe
        credit_t sum;                                   // credit plus inserted coin
        credit_t push_val;                              // value of coin being queued

        // coin strobes in priority order 1, 2, 5
        always_comb begin
                coin_in = 1'b1;
                in_coin = COIN_1;
                if (!coin1_n) begin
                        in_coin = COIN_1;
                end else if (!coin2_n) begin
                        in_coin = COIN_2;
                end else if (!coin5_n) begin
                        in_coin = COIN_5;
                end else begin
                        coin_in = 1'b0;                 // no coin this cycle
                end
        end

        assign sum = credit + coin_value(in_coin);      // at most 9 + 5, fits 4 bits

        // greedy split, largest coin not above the change
        always_comb begin
                if (change_q >= coin_value(COIN_5)) begin
                        push_coin = COIN_5;
                end else if (change_q >= coin_value(COIN_2)) begin
                        push_coin = COIN_2;
                end else begin
                        push_coin = COIN_1;
                end
        end

        assign push_val = coin_value(push_coin);
        assign busy     = (change_q != '0);             // strobes locked out meanwhile
        assign push     = busy && !full;                // stall on back-pressure

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        credit     <= '0;
                        change_q   <= '0;
                        vend_water <= 1'b0;
                end else begin
                        vend_water <= 1'b0;             // pulse by default low
                        if (busy) begin
                                if (push) begin
                                        change_q <= change_q - push_val; // one coin gone
                                end
                        end else if (coin_in) begin
                                if (sum > CREDIT_MAX) begin
                                        change_q <= coin_value(in_coin); // bounce the coin
                                end else begin
                                        credit <= sum;
                                end
                        end else if (!water_n) begin
                                // water beats refund, short credit makes it a no-op
                                if (credit >= PRICE_WATER) begin
                                        vend_water <= 1'b1;
                                        change_q   <= credit - PRICE_WATER;
                                        credit     <= '0;
                                end
                        end else if (!refund_n) begin
                                change_q <= credit;     // zero credit leaves change at 0
                                credit   <= '0;
                        end
                end
        end

endmodule

// ==== rtl/vend_pkg.sv ====
package vend_pkg;

        typedef logic [3:0] credit_t;                   // credit and change amounts, 0..15

        typedef enum logic [1:0] {
                COIN_1 = 2'd0,                          // one unit coin
                COIN_2 = 2'd1,                          // two unit coin
                COIN_5 = 2'd2                           // five unit coin
        } coin_t;

        localparam credit_t CREDIT_MAX  = 4'd9;         // highest credit the machine holds
        localparam credit_t PRICE_WATER = 4'd7;         // price of one water

        localparam int FIFO_DEPTH = 4;                  // change queue entries
        localparam int FIFO_AW    = 2;                  // change queue pointer width
        localparam int HOPPER_GAP = 3;                  // idle cycles after each payout

        // face value of a coin code
        function automatic credit_t coin_value(input coin_t c);
                credit_t v;
                case (c)
                        COIN_1:  v = 4'd1;
                        COIN_2:  v = 4'd2;
                        COIN_5:  v = 4'd5;
                        default: v = 4'd0;              // unused code 2'b11
                endcase
                return v;
        endfunction

endpackage

// ==== rtl/vend_top.sv ====
module vend_top
        import vend_pkg::*;
(
        input  logic    clk,
        input  logic    rst,
        input  logic    coin1_n,
        input  logic    coin2_n,
        input  logic    coin5_n,
        input  logic    water_n,
        input  logic    refund_n,
        output credit_t credit,
        output logic    vend_water,
        output logic    ret1,
        output logic    ret2,
        output logic    ret5,
        output logic    busy
);

        logic  push;                                    // credit keeper to queue
        coin_t push_coin;
        logic  full;
        logic  pop;                                     // hopper to queue
        coin_t head_coin;
        logic  empty;

        vend_credit i_credit (
                .clk        (clk),
                .rst        (rst),
                .coin1_n    (coin1_n),
                .coin2_n    (coin2_n),
                .coin5_n    (coin5_n),
                .water_n    (water_n),
                .refund_n   (refund_n),
                .full       (full),
                .credit     (credit),
                .vend_water (vend_water),
                .busy       (busy),
                .push       (push),
                .push_coin  (push_coin)
        );

        change_fifo i_fifo (
                .clk       (clk),
                .rst       (rst),
                .push      (push),
                .push_coin (push_coin),
                .pop       (pop),
                .head_coin (head_coin),
                .full      (full),
                .empty     (empty)
        );

        coin_hopper i_hopper (
                .clk       (clk),
                .rst       (rst),
                .head_coin (head_coin),
                .empty     (empty),
                .pop       (pop),
                .ret1      (ret1),
                .ret2      (ret2),
                .ret5      (ret5)
        );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vending controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_vend
out=$(./obj_dir/Vtb_vend 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"; then
        exit 0
fi
exit 1

// ==== tb/tb_vend.sv ====
module tb_vend
        import vend_pkg::*;
();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int OP_COIN1      = 'h1;             // operation codes in the golden file
        localparam int OP_COIN2      = 'h2;
        localparam int OP_COIN5      = 'h5;
        localparam int OP_WATER      = 'ha;
        localparam int OP_REFUND     = 'hf;
        localparam int WATCH_CYCLES  = 20;              // quiet cycles after the change is paid
        localparam int WAIT_LIMIT    = 40;              // cycles allowed for one payout
        localparam int CYCLES_PER_OP = 60;

        logic    clk = 1'b0;
        logic    rst;
        logic    coin1_n;
        logic    coin2_n;
        logic    coin5_n;
        logic    water_n;
        logic    refund_n;
        credit_t credit;
        logic    vend_water;
        logic    ret1;
        logic    ret2;
        logic    ret5;
        logic    busy;

        int      op_q[$];                               // one entry per golden line
        credit_t exp_credit_q[$];
        int      exp_vend_q[$];
        int      exp5_q[$];
        int      exp2_q[$];
        int      exp1_q[$];

        int      n_ret1;                                // running pulse counts
        int      n_ret2;
        int      n_ret5;
        int      n_vend;
        int      credit_errs;
        int      vend_errs;
        int      coin_errs;
        int      lock_errs;
        int      wait_errs;
        int      cycles;
        int      cycle_limit;                           // 0 until the golden file is read
        logic [31:0] lcg_state = 32'h72c9_1d9a;

        always #5 clk = ~clk;                           // 10 ns period

        vend_top i_dut (
                .clk        (clk),
                .rst        (rst),
                .coin1_n    (coin1_n),
                .coin2_n    (coin2_n),
                .coin5_n    (coin5_n),
                .water_n    (water_n),
                .refund_n   (refund_n),
                .credit     (credit),
                .vend_water (vend_water),
                .ret1       (ret1),
                .ret2       (ret2),
                .ret5       (ret5),
                .busy       (busy)
        );

        // pulses counted as seen at each edge
        always @(posedge clk) begin
                if (ret1) n_ret1 <= n_ret1 + 1;
                if (ret2) n_ret2 <= n_ret2 + 1;
                if (ret5) n_ret5 <= n_ret5 + 1;
                if (vend_water) n_vend <= n_vend + 1;
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycle_limit > 0 && cycles >= cycle_limit) begin
                        $display("run stopped after %0d cycles because an operation hung",
                                 cycles);
                        $display("TESTBENCH FAILED");
                        $finish;
                end
        end

        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        task automatic read_golden(output bit ok);
                int    fd;
                int    n;
                int    op, cr, vd, c5, c2, c1;
                bit    bad;
                string line;
                ok  = 1'b0;
                bad = 1'b0;
                fd  = $fopen("tb/vend_golden.txt", "r");
                if (fd == 0) begin
                        $display("could not open tb/vend_golden.txt");
                end else begin
                        while (!$feof(fd)) begin
                                line = "";
                                if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
                                        n = $sscanf(line, "%h %h %h %h %h %h",
                                                    op, cr, vd, c5, c2, c1);
                                        if (n != 6 || !(op inside {OP_COIN1, OP_COIN2, OP_COIN5,
                                                                   OP_WATER, OP_REFUND})) begin
                                                $display("unreadable golden line: %s", line);
                                                bad = 1'b1;
                                        end else begin
                                                op_q.push_back(op);
                                                exp_credit_q.push_back(credit_t'(cr));
                                                exp_vend_q.push_back(vd);
                                                exp5_q.push_back(c5);
                                                exp2_q.push_back(c2);
                                                exp1_q.push_back(c1);
                                        end
                                end
                        end
                        $fclose(fd);
                        ok = (op_q.size() > 0) && !bad;
                end
        endtask

        task automatic drive_strobe(input int op);
                case (op)
                        OP_COIN1:  coin1_n  <= 1'b0;
                        OP_COIN2:  coin2_n  <= 1'b0;
                        OP_COIN5:  coin5_n  <= 1'b0;
                        OP_WATER:  water_n  <= 1'b0;
                        OP_REFUND: refund_n <= 1'b0;
                        default:   ;                    // codes are screened on reading
                endcase
        endtask

        task automatic release_strobes();
                coin1_n  <= 1'b1;
                coin2_n  <= 1'b1;
                coin5_n  <= 1'b1;
                water_n  <= 1'b1;
                refund_n <= 1'b1;
        endtask

        task automatic check_credit(input int idx, input credit_t exp, input credit_t act);
                if (act !== exp) begin
                        credit_errs++;
                        $display("Fail credit after op %0d: expected %h actual %h",
                                 idx, exp, act);
                end
        endtask

        task automatic check_vend(input int idx, input int exp, input int act);
                if (act != exp) begin
                        vend_errs++;
                        $display("Fail vend_water pulses in op %0d: expected %h actual %h",
                                 idx, exp, act);
                end
        endtask

        task automatic check_coins(input int idx, input int exp5, input int exp2, input int exp1,
                                   input int act5, input int act2, input int act1);
                if (act5 != exp5) begin
                        coin_errs++;
                        $display("Fail ret5 pulses in op %0d: expected %h actual %h",
                                 idx, exp5, act5);
                end
                if (act2 != exp2) begin
                        coin_errs++;
                        $display("Fail ret2 pulses in op %0d: expected %h actual %h",
                                 idx, exp2, act2);
                end
                if (act1 != exp1) begin
                        coin_errs++;
                        $display("Fail ret1 pulses in op %0d: expected %h actual %h",
                                 idx, exp1, act1);
                end
        endtask

        // one strobe, payout wait, quiet watch, checks, random idle gap
        task automatic run_op(input int idx);
                int          b1, b2, b5, bv;
                int          change, paid, waited;
                logic [31:0] rnd;
                b1     = n_ret1;
                b2     = n_ret2;
                b5     = n_ret5;
                bv     = n_vend;
                change = 5 * exp5_q[idx] + 2 * exp2_q[idx] + exp1_q[idx];
                @(posedge clk);
                drive_strobe(op_q[idx]);
                @(posedge clk);
                release_strobes();
                if (change != 0) coin5_n <= 1'b0;       // sampled while change is loaded
                @(posedge clk);
                release_strobes();
                if (change != 0 && !busy) begin
                        lock_errs++;
                        $display("busy was low when the extra coin of op %0d was sampled", idx);
                end
                paid   = 0;
                waited = 0;
                while (paid < change && waited < WAIT_LIMIT) begin
                        @(posedge clk);
                        waited++;
                        paid = 5 * (n_ret5 - b5) + 2 * (n_ret2 - b2) + (n_ret1 - b1);
                end
                if (paid < change) begin
                        wait_errs++;
                        $display("op %0d (code %h) never paid out its change of %0d",
                                 idx, op_q[idx], change);
                end
                repeat (WATCH_CYCLES) @(posedge clk);   // extra coins would show here
                check_credit(idx, exp_credit_q[idx], credit);
                check_vend(idx, exp_vend_q[idx], n_vend - bv);
                check_coins(idx, exp5_q[idx], exp2_q[idx], exp1_q[idx],
                            n_ret5 - b5, n_ret2 - b2, n_ret1 - b1);
                rnd = lcg_next();
                repeat (1 + int'(rnd[18:16])) @(posedge clk);
        endtask

        initial begin
                bit ok;
                int assert_errs;
                int total_errs;
                rst <= 1'b1;
                release_strobes();
                read_golden(ok);
                if (!ok) begin
                        $display("golden file missing, empty or unreadable");
                        $display("TESTBENCH FAILED");
                        $finish;
                end else begin
                        cycle_limit = op_q.size() * CYCLES_PER_OP + 200;
                        repeat (16) @(posedge clk);
                        rst <= 1'b0;
                        @(posedge clk);
                        for (int i = 0; i < op_q.size(); i++) begin
                                run_op(i);
                        end
                        assert_errs = i_dut.i_fifo.i_fifo_chk.fail_count
                                      + i_dut.i_hopper.i_hopper_chk.fail_count;
                        total_errs  = credit_errs + vend_errs + coin_errs + lock_errs
                                      + wait_errs + assert_errs;
                        $display("errors: credit %0d vend %0d coins %0d lock %0d wait %0d sva %0d",
                                 credit_errs, vend_errs, coin_errs, lock_errs, wait_errs,
                                 assert_errs);
                        if (total_errs == 0) begin
                                $display("TESTBENCH PASSED");
                        end else begin
                                $display("TESTBENCH FAILED");
                        end
                        $finish;
                end
        end

endmodule

// ==== tb/vend_chk.sv ====
module vend_chk
        import vend_pkg::*;
(
        input logic clk,
        input logic rst,
        input logic push,                               // tied low in the hopper
        input logic full,
        input logic pop,
        input logic empty,
        input logic ret1,                               // tied low in the queue
        input logic ret2,
        input logic ret5
);
        timeunit 1ns;
        timeprecision 1ps;

        int since_pop;                                  // cycles since the last pop, saturating
        int fail_count;                                 // assertion failures in this instance

        always @(posedge clk or posedge rst) begin
                if (rst) begin
                        since_pop <= HOPPER_GAP;
                end else if (pop) begin
                        since_pop <= 0;
                end else if (since_pop < HOPPER_GAP) begin
                        since_pop <= since_pop + 1;
                end
        end

        push_not_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
                else begin
                        fail_count++;
                        $error("coin pushed into a full change queue");
                end

        pop_not_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
                else begin
                        fail_count++;
                        $error("coin popped from an empty change queue");
                end

        one_return: assert property (@(posedge clk) disable iff (rst)
                        $onehot0({ret1, ret2, ret5}))
                else begin
                        fail_count++;
                        $error("more than one return line high");
                end

        pop_spacing: assert property (@(posedge clk) disable iff (rst)
                        pop |-> since_pop >= HOPPER_GAP)
                else begin
                        fail_count++;
                        $error("hopper popped again inside its recovery gap");
                end

endmodule

bind change_fifo vend_chk i_fifo_chk (
        .clk   (clk),
        .rst   (rst),
        .push  (push),
        .full  (full),
        .pop   (pop),
        .empty (empty),
        .ret1  (1'b0),
        .ret2  (1'b0),
        .ret5  (1'b0)
);

bind coin_hopper vend_chk i_hopper_chk (
        .clk   (clk),
        .rst   (rst),
        .push  (1'b0),
        .full  (1'b0),
        .pop   (pop),
        .empty (empty),
        .ret1  (ret1),
        .ret2  (ret2),
        .ret5  (ret5)
);

// ==== tb/vend_golden.txt ====
# op credit vend n5 n2 n1, all hex; op 1 2 5 insert that coin, a buys water, f refunds
# credit is the value after the op, vend the water pulses, n5 n2 n1 the coins paid back
1 1 0 0 0 0
2 3 0 0 0 0
5 8 0 0 0 0
2 8 0 0 1 0
1 9 0 0 0 0
1 9 0 0 0 1
a 0 1 0 1 0
a 0 0 0 0 0
5 5 0 0 0 0
a 5 0 0 0 0
2 7 0 0 0 0
5 7 0 1 0 0
a 0 1 0 0 0
5 5 0 0 0 0
2 7 0 0 0 0
1 8 0 0 0 0
f 0 0 1 1 1
f 0 0 0 0 0
5 5 0 0 0 0
5 5 0 1 0 0
2 7 0 0 0 0
2 9 0 0 0 0
f 0 0 1 2 0
1 1 0 0 0 0
1 2 0 0 0 0
f 0 0 0 1 0

// ==== verilog.f ====
rtl/vend_pkg.sv
rtl/vend_credit.sv
rtl/change_fifo.sv
rtl/coin_hopper.sv
rtl/vend_top.sv
tb/vend_chk.sv
tb/tb_vend.sv
